// ==== compile.f ====
+incdir+tests
src/proc_pkg.sv
src/reg_file.sv
src/inst_fetch.sv
src/inst_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/proc_top.sv
tests/tb_proc.sv

// ==== run.sh ====
#!/bin/sh
# Build the processor testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_proc -o vtb_proc

out=$(./obj_dir/vtb_proc 2>&1) || true
echo "$out"
echo "$out" | grep -q "TEST PASS"

// ==== tests/isa_model.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Expected data memory traffic in program order
logic [DATA_W-1:0] exp_st_addr [$];
logic [DATA_W-1:0] exp_st_data [$];
logic [DATA_W-1:0] exp_ld_addr [$];
int                model_undef;
int                model_halt_addr;

// Executes the program one instruction at a time, no pipeline at all
task automatic run_model();
   logic [DATA_W-1:0] mregs [32];
   logic [DATA_W-1:0] mmem [DMEM_WORDS];
   inst_word_u        w;
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] b;
   logic [DATA_W-1:0] sx;
   logic [DATA_W-1:0] zx;
   logic [DATA_W-1:0] addr;
   int                pc;
   logic              stop;

   for (int r = 0; r < 32; r++) begin
      mregs[5'(r)] = '0;
   end
   // Same starting contents as the memory the DUT sees
   for (int i = 0; i < DMEM_WORDS; i++) begin
      mmem[8'(i)] = dmem[8'(i)];
   end
   model_undef     = 0;
   model_halt_addr = PROG_LEN - 1;
   pc              = 0;
   stop            = 1'b0;

   while (!stop && pc < PROG_LEN) begin
      w    = imem[6'(pc)];
      a    = mregs[w.r.rs];
      b    = mregs[w.r.rt];
      sx   = {{(DATA_W-IMM_W){w.i.imm[IMM_W-1]}}, w.i.imm};
      zx   = {{(DATA_W-IMM_W){1'b0}}, w.i.imm};
      addr = a + sx;
      case (w.r.opc)
         OPC_ADD:  mregs[w.r.rd] = a + b;
         OPC_SUB:  mregs[w.r.rd] = a - b;
         OPC_AND:  mregs[w.r.rd] = a & b;
         OPC_OR:   mregs[w.r.rd] = a | b;
         OPC_XOR:  mregs[w.r.rd] = a ^ b;
         OPC_SLT:  mregs[w.r.rd] = ($signed(a) < $signed(b)) ? DATA_W'(1) : '0;
         OPC_ADDI: mregs[w.i.rt] = a + sx;
         OPC_ORI:  mregs[w.i.rt] = a | zx;
         OPC_XORI: mregs[w.i.rt] = a ^ zx;
         OPC_LD: begin
            exp_ld_addr.push_back(addr);
            mregs[w.i.rt] = mmem[addr[7:0]];
         end
         OPC_ST: begin
            exp_st_addr.push_back(addr);
            exp_st_data.push_back(b);
            mmem[addr[7:0]] = b;
         end
         OPC_HALT: begin
            model_halt_addr = pc;
            stop            = 1'b1;
         end
         OPC_NOP: ;
         default: model_undef++;
      endcase
      pc++;
   end
endtask

`endif

// ==== tests/tb_proc.sv ====
`default_nettype none

module tb_proc;

   import proc_pkg::*;

   localparam int DATA_W        = 32;
   localparam int CLK_PERIOD    = 40;
   localparam int DRIVE_DLY     = 2;
   localparam int RESET_CYCLES  = 8;
   localparam int PROG_LEN      = 64;
   localparam int DMEM_WORDS    = 256;
   localparam int DRAIN_CYCLES  = 8;
   localparam int WATCHDOG_TIME = (PROG_LEN * 6 + 50) * CLK_PERIOD;

   logic              clk;
   logic              rst_n;
   inst_word_u        inst_i;
   logic [DATA_W-1:0] data_i;
   logic [DATA_W-1:0] iaddr_o;
   logic [DATA_W-1:0] daddr_o;
   logic [DATA_W-1:0] data_o;
   logic              we_o;
   logic              re_o;
   logic              err_o;
   logic              halt_o;

   // Program and data memories
   // The data side wraps on the low 8 address bits
   inst_word_u        imem [PROG_LEN];
   logic [DATA_W-1:0] dmem [DMEM_WORDS];

   logic [31:0]       lfsr_q;
   int                st_seen;
   int                ld_seen;
   int                err_count;
   logic [DATA_W-1:0] max_iaddr;
   logic              halted;

   `include "isa_model.svh"

   proc_top #(.DATA_W(DATA_W)) uut (
      .clk(clk), .rst_n(rst_n),
      .iaddr_o(iaddr_o), .inst_i(inst_i),
      .daddr_o(daddr_o), .data_o(data_o), .we_o(we_o), .re_o(re_o), .data_i(data_i),
      .err_o(err_o), .halt_o(halt_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_addr(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s, got address %h expected %h", $time, what, got, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   // One step per bit returned
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         val    = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic preload_data();
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[8'(i)] = lfsr_bits(32);
      end
   endtask

   // Registers come from r0..r7 so that hazards are frequent
   task automatic build_program();
      logic [3:0]            sel;
      logic [OPC_W-1:0]      opc;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [IMM_W-1:0]      imm;
      for (int p = 0; p < PROG_LEN - 1; p++) begin
         sel = 4'(lfsr_bits(4));
         rs  = REG_ADDR_W'(lfsr_bits(3));
         rt  = REG_ADDR_W'(lfsr_bits(3));
         rd  = REG_ADDR_W'(lfsr_bits(3));
         case (sel)
            4'd0:         opc = OPC_ADD;
            4'd1:         opc = OPC_SUB;
            4'd2:         opc = OPC_AND;
            4'd3:         opc = OPC_OR;
            4'd4:         opc = OPC_XOR;
            4'd5:         opc = OPC_SLT;
            4'd6, 4'd14:  opc = OPC_ADDI;
            4'd7:         opc = OPC_ORI;
            4'd8:         opc = OPC_XORI;
            4'd9, 4'd10:  opc = OPC_LD;
            4'd11, 4'd12: opc = OPC_ST;
            4'd13:        opc = OPC_NOP;
            // 0x18 to 0x1f are all undefined
            default:      opc = {3'b011, 3'(lfsr_bits(3))};
         endcase
         if (opc == OPC_LD || opc == OPC_ST) begin
            imm = IMM_W'(lfsr_bits(8));
         end else begin
            imm = IMM_W'(lfsr_bits(16));
         end
         if (sel < 4'd6) begin
            imem[6'(p)] = inst_word_u'({opc, rs, rt, rd, 11'b0});
         end else begin
            imem[6'(p)] = inst_word_u'({opc, rs, rt, imm});
         end
      end
      imem[6'(PROG_LEN - 1)] = inst_word_u'({OPC_HALT, {(INST_W-OPC_W){1'b0}}});
   endtask

   // Memories answer for the address held this cycle
   // A store commits before the read
   task automatic drive_memories();
      if (we_o) begin
         dmem[daddr_o[7:0]] = data_o;
      end
      if (iaddr_o < DATA_W'(PROG_LEN)) begin
         inst_i = imem[iaddr_o[5:0]];
      end else begin
         inst_i = NOP_INST;
      end
      data_i = dmem[daddr_o[7:0]];
   endtask

   task automatic check_idle_outputs(input string when);
      check_addr(iaddr_o, '0, {"iaddr_o ", when});
      check_flag(we_o, 1'b0, {"we_o ", when});
      check_flag(re_o, 1'b0, {"re_o ", when});
      check_flag(halt_o, 1'b0, {"halt_o ", when});
      check_flag(err_o, 1'b0, {"err_o ", when});
   endtask

   task automatic check_memory_ports();
      if (we_o) begin
         if (st_seen >= exp_st_addr.size()) begin
            stop_with_failure("The processor issued more stores than the program holds");
         end else begin
            check_addr(daddr_o, exp_st_addr[st_seen], "store address");
            check_word(data_o, exp_st_data[st_seen], "store data");
            st_seen++;
         end
      end
      if (re_o) begin
         if (ld_seen >= exp_ld_addr.size()) begin
            stop_with_failure("The processor issued more loads than the program holds");
         end else begin
            check_addr(daddr_o, exp_ld_addr[ld_seen], "load address");
            ld_seen++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      inst_i    = NOP_INST;
      data_i    = '0;
      lfsr_q    = 32'h2066;
      st_seen   = 0;
      ld_seen   = 0;
      err_count = 0;
      max_iaddr = '0;
      halted    = 1'b0;

      preload_data();
      build_program();
      run_model();

      repeat (RESET_CYCLES) begin
         @(posedge clk);
         #DRIVE_DLY;
         check_idle_outputs("during reset");
      end
      rst_n = 1'b1;
      drive_memories();

      // Late in the first cycle out of reset, just ahead of the next edge
      #(CLK_PERIOD - 2 * DRIVE_DLY);
      check_idle_outputs("after reset");

      while (!halted) begin
         @(posedge clk);
         #DRIVE_DLY;
         if (iaddr_o > max_iaddr) begin
            max_iaddr = iaddr_o;
         end
         check_memory_ports();
         if (halt_o) begin
            halted = 1'b1;
         end else if (err_o) begin
            err_count++;
         end
         drive_memories();
      end

      // Fetch parks on the HALT word so this is the highest address seen
      check_addr(max_iaddr, DATA_W'(model_halt_addr), "highest fetch address");
      check_word(DATA_W'(err_count), DATA_W'(model_undef), "err_o pulse count");

      repeat (DRAIN_CYCLES) begin
         @(posedge clk);
         #DRIVE_DLY;
         check_flag(we_o, 1'b0, "we_o after halt");
         check_flag(halt_o, 1'b1, "halt_o held after halt");
         drive_memories();
      end

      if (st_seen == exp_st_addr.size() && ld_seen == exp_ld_addr.size()) begin
         $display("%0d stores, %0d loads and %0d undefined opcodes matched",
                  st_seen, ld_seen, err_count);
         $display("TEST PASS");
         $finish;
      end else begin
         $display("Halted after %0d of %0d stores and %0d of %0d loads",
                  st_seen, exp_st_addr.size(), ld_seen, exp_ld_addr.size());
         $display("TEST FAIL");
         $fatal(1);
      end
   end

   // Bounded by six cycles per instruction plus reset and drain
   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired at %0t, the processor never halted", $time);
      $display("TEST FAIL");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== src/proc_top.sv ====
`default_nettype none

module proc_top #(
   parameter int DATA_W = 32
) (
   input  wire                       clk,
   input  wire                       rst_n,
   // Instruction memory
   output wire [DATA_W-1:0]          iaddr_o,
   input  wire proc_pkg::inst_word_u inst_i,
   // Data memory
   output wire [DATA_W-1:0]          daddr_o,
   output wire [DATA_W-1:0]          data_o,
   output wire                       we_o,
   output wire                       re_o,
   input  wire [DATA_W-1:0]          data_i,
   // Status
   output wire                       err_o,
   output wire                       halt_o
);

   import proc_pkg::*;

   logic                  stall;
   logic                  halt_hold;
   inst_word_u            if_inst;

   // ID/EX
   logic [OPC_W-1:0]      ex_opc;
   logic [REG_ADDR_W-1:0] ex_rs;
   logic [REG_ADDR_W-1:0] ex_rt;
   logic [REG_ADDR_W-1:0] ex_dst;
   logic [DATA_W-1:0]     ex_rs_val;
   logic [DATA_W-1:0]     ex_rt_val;
   logic [IMM_W-1:0]      ex_imm;
   logic                  ex_reg_we;
   logic                  ex_mem_rd;
   logic                  ex_mem_wr;
   logic                  ex_halt;

   // EX/MEM
   logic                  mem_reg_we;
   logic [REG_ADDR_W-1:0] mem_dst;
   logic [DATA_W-1:0]     mem_alu;
   logic                  mem_halt;

   // Writeback, also the second forwarding source
   logic                  wb_we;
   logic [REG_ADDR_W-1:0] wb_addr;
   logic [DATA_W-1:0]     wb_data;

   inst_fetch #(.DATA_W(DATA_W)) u_fetch (
      .clk(clk), .rst_n(rst_n), .stall_i(stall), .halt_hold_i(halt_hold),
      .inst_i(inst_i), .iaddr_o(iaddr_o), .if_inst_o(if_inst)
   );

   inst_decode #(.DATA_W(DATA_W)) u_decode (
      .clk(clk), .rst_n(rst_n), .if_inst_i(if_inst),
      .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
      .stall_o(stall), .halt_hold_o(halt_hold), .err_o(err_o),
      .ex_opc_o(ex_opc), .ex_rs_o(ex_rs), .ex_rt_o(ex_rt), .ex_dst_o(ex_dst),
      .ex_rs_val_o(ex_rs_val), .ex_rt_val_o(ex_rt_val), .ex_imm_o(ex_imm),
      .ex_reg_we_o(ex_reg_we), .ex_mem_rd_o(ex_mem_rd), .ex_mem_wr_o(ex_mem_wr),
      .ex_halt_o(ex_halt)
   );

   alu_execute #(.DATA_W(DATA_W)) u_execute (
      .clk(clk), .rst_n(rst_n),
      .ex_opc_i(ex_opc), .ex_rs_i(ex_rs), .ex_rt_i(ex_rt), .ex_dst_i(ex_dst),
      .ex_rs_val_i(ex_rs_val), .ex_rt_val_i(ex_rt_val), .ex_imm_i(ex_imm),
      .ex_reg_we_i(ex_reg_we), .ex_mem_rd_i(ex_mem_rd), .ex_mem_wr_i(ex_mem_wr),
      .ex_halt_i(ex_halt),
      .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
      .daddr_o(daddr_o), .data_o(data_o), .we_o(we_o), .re_o(re_o),
      .mem_reg_we_o(mem_reg_we), .mem_dst_o(mem_dst), .mem_alu_o(mem_alu),
      .mem_halt_o(mem_halt)
   );

   result_writeback #(.DATA_W(DATA_W)) u_writeback (
      .clk(clk), .rst_n(rst_n),
      .mem_reg_we_i(mem_reg_we), .mem_dst_i(mem_dst), .mem_alu_i(mem_alu),
      .mem_halt_i(mem_halt), .re_i(re_o), .data_i(data_i),
      .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data), .halt_o(halt_o)
   );

endmodule

`default_nettype wire

// ==== src/result_writeback.sv ====
`default_nettype none

module result_writeback #(
   parameter int DATA_W = 32
) (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             mem_reg_we_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]  mem_dst_i,
   input  wire [DATA_W-1:0]                mem_alu_i,
   input  wire                             mem_halt_i,
   input  wire                             re_i,
   input  wire [DATA_W-1:0]                data_i,
   output logic                            wb_we_o,
   output logic [proc_pkg::REG_ADDR_W-1:0] wb_addr_o,
   output logic [DATA_W-1:0]               wb_data_o,
   output logic                            halt_o
);

   logic [DATA_W-1:0] alu_q;
   logic [DATA_W-1:0] load_q;
   logic              load_sel_q;

   // MEM/WB control, halt stays up until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_we_o <= 1'b0;
         halt_o  <= 1'b0;
      end else begin
         wb_we_o <= mem_reg_we_i;
         halt_o  <= halt_o | mem_halt_i;
      end
   end

   // Memory answers in the same cycle, so data_i is captured with the rest
   always_ff @(posedge clk) begin
      wb_addr_o  <= mem_dst_i;
      alu_q      <= mem_alu_i;
      load_q     <= data_i;
      load_sel_q <= re_i;
   end

   assign wb_data_o = load_sel_q ? load_q : alu_q;

endmodule

`default_nettype wire

// ==== src/alu_execute.sv ====
`default_nettype none

module alu_execute #(
   parameter int DATA_W = 32
) (
   input  wire                             clk,
   input  wire                             rst_n,
   // ID/EX register
   input  wire [proc_pkg::OPC_W-1:0]       ex_opc_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]  ex_rs_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]  ex_rt_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]  ex_dst_i,
   input  wire [DATA_W-1:0]                ex_rs_val_i,
   input  wire [DATA_W-1:0]                ex_rt_val_i,
   input  wire [proc_pkg::IMM_W-1:0]       ex_imm_i,
   input  wire                             ex_reg_we_i,
   input  wire                             ex_mem_rd_i,
   input  wire                             ex_mem_wr_i,
   input  wire                             ex_halt_i,
   // Writeback forwarding source
   input  wire                             wb_we_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]  wb_addr_i,
   input  wire [DATA_W-1:0]                wb_data_i,
   // Data memory, straight from EX/MEM
   output logic [DATA_W-1:0]               daddr_o,
   output logic [DATA_W-1:0]               data_o,
   output logic                            we_o,
   output logic                            re_o,
   // Rest of EX/MEM
   output logic                            mem_reg_we_o,
   output logic [proc_pkg::REG_ADDR_W-1:0] mem_dst_o,
   output logic [DATA_W-1:0]               mem_alu_o,
   output logic                            mem_halt_o
);

   import proc_pkg::*;

   logic [DATA_W-1:0] op_a, op_b;
   logic [DATA_W-1:0] imm_sx, imm_zx;
   logic [DATA_W-1:0] alu_res;

   ////////////////////////////////////////////////////////////////////////////
   // Forwarding
   ////////////////////////////////////////////////////////////////////////////

   // EX/MEM first, load data is not there yet so skip it, then writeback
   function automatic logic [DATA_W-1:0] fwd_operand(
      input logic [REG_ADDR_W-1:0] src,
      input logic [DATA_W-1:0]     id_val
   );
      if (mem_reg_we_o && !re_o && (mem_dst_o == src)) begin
         return mem_alu_o;
      end else if (wb_we_i && (wb_addr_i == src)) begin
         return wb_data_i;
      end
      return id_val;
   endfunction

   always_comb begin
      op_a = fwd_operand(ex_rs_i, ex_rs_val_i);
      op_b = fwd_operand(ex_rt_i, ex_rt_val_i);
   end

   ////////////////////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////////////////////

   assign imm_sx = {{(DATA_W-IMM_W){ex_imm_i[IMM_W-1]}}, ex_imm_i};
   assign imm_zx = {{(DATA_W-IMM_W){1'b0}}, ex_imm_i};

   always_comb begin
      case (ex_opc_i)
         OPC_ADD:                  alu_res = op_a + op_b;
         OPC_SUB:                  alu_res = op_a - op_b;
         OPC_AND:                  alu_res = op_a & op_b;
         OPC_OR:                   alu_res = op_a | op_b;
         OPC_XOR:                  alu_res = op_a ^ op_b;
         OPC_SLT:                  alu_res = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         // Loads and stores share the address adder
         OPC_ADDI, OPC_LD, OPC_ST: alu_res = op_a + imm_sx;
         OPC_ORI:                  alu_res = op_a | imm_zx;
         OPC_XORI:                 alu_res = op_a ^ imm_zx;
         default:                  alu_res = '0;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_reg_we_o <= 1'b0;
         we_o         <= 1'b0;
         re_o         <= 1'b0;
         mem_halt_o   <= 1'b0;
      end else begin
         mem_reg_we_o <= ex_reg_we_i;
         we_o         <= ex_mem_wr_i;
         re_o         <= ex_mem_rd_i;
         mem_halt_o   <= ex_halt_i;
      end
   end

   always_ff @(posedge clk) begin
      mem_dst_o <= ex_dst_i;
      mem_alu_o <= alu_res;
      data_o    <= op_b;
   end

   assign daddr_o = mem_alu_o;

   // Decode never issues an opcode that is both load and store
   a_single_mem_strobe : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(we_o && re_o)
   );

endmodule

`default_nettype wire

// ==== src/inst_decode.sv ====
`default_nettype none

module inst_decode #(
   parameter int DATA_W = 32
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire proc_pkg::inst_word_u          if_inst_i,
   input  wire                                wb_we_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0]     wb_addr_i,
   input  wire [DATA_W-1:0]                   wb_data_i,
   output logic                               stall_o,
   output logic                               halt_hold_o,
   output logic                               err_o,
   // ID/EX register
   output logic [proc_pkg::OPC_W-1:0]         ex_opc_o,
   output logic [proc_pkg::REG_ADDR_W-1:0]    ex_rs_o,
   output logic [proc_pkg::REG_ADDR_W-1:0]    ex_rt_o,
   output logic [proc_pkg::REG_ADDR_W-1:0]    ex_dst_o,
   output logic [DATA_W-1:0]                  ex_rs_val_o,
   output logic [DATA_W-1:0]                  ex_rt_val_o,
   output logic [proc_pkg::IMM_W-1:0]         ex_imm_o,
   output logic                               ex_reg_we_o,
   output logic                               ex_mem_rd_o,
   output logic                               ex_mem_wr_o,
   output logic                               ex_halt_o
);

   import proc_pkg::*;

   logic [OPC_W-1:0]      opc;
   logic                  is_r, is_i_alu, is_ld, is_st, is_halt, is_nop;
   logic                  undef;
   logic                  uses_rs, uses_rt;
   logic                  bubble;
   logic                  halt_seen;
   logic [REG_ADDR_W-1:0] dst;
   logic [DATA_W-1:0]     rs_val, rt_val;

   ////////////////////////////////////////////////////////////////////////////
   // Opcode decode
   ////////////////////////////////////////////////////////////////////////////

   assign opc      = if_inst_i.r.opc;
   assign is_r     = opc inside {OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_XOR, OPC_SLT};
   assign is_i_alu = opc inside {OPC_ADDI, OPC_ORI, OPC_XORI};
   assign is_ld    = (opc == OPC_LD);
   assign is_st    = (opc == OPC_ST);
   assign is_halt  = (opc == OPC_HALT);
   assign is_nop   = (opc == OPC_NOP);
   assign undef    = !(is_r | is_i_alu | is_ld | is_st | is_halt | is_nop);

   // Which source fields are real register reads
   assign uses_rs = is_r | is_i_alu | is_ld | is_st;
   assign uses_rt = is_r | is_st;

   // R-format writes rd, the I-format ones write rt
   assign dst = is_r ? if_inst_i.r.rd : if_inst_i.i.rt;

   reg_file #(.DATA_W(DATA_W)) u_rf (
      .clk(clk), .rst_n(rst_n),
      .rd_addr_a_i(if_inst_i.r.rs), .rd_addr_b_i(if_inst_i.r.rt),
      .rd_data_a_o(rs_val), .rd_data_b_o(rt_val),
      .wr_en_i(wb_we_i), .wr_addr_i(wb_addr_i), .wr_data_i(wb_data_i)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Hazard and halt control
   ////////////////////////////////////////////////////////////////////////////

   // Load in EX whose result is needed here, not forwardable yet
   assign stall_o = ex_mem_rd_o &
                    ((uses_rs & (if_inst_i.r.rs == ex_dst_o)) |
                     (uses_rt & (if_inst_i.r.rt == ex_dst_o)));

   assign halt_hold_o = is_halt | halt_seen;

   // Undefined opcodes travel on as NOP
   assign bubble = stall_o | halt_seen | undef;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_opc_o    <= OPC_NOP;
         ex_reg_we_o <= 1'b0;
         ex_mem_rd_o <= 1'b0;
         ex_mem_wr_o <= 1'b0;
         ex_halt_o   <= 1'b0;
         halt_seen   <= 1'b0;
         err_o       <= 1'b0;
      end else begin
         ex_opc_o    <= bubble ? OPC_NOP : opc;
         ex_reg_we_o <= !bubble && (is_r || is_i_alu || is_ld);
         ex_mem_rd_o <= !bubble && is_ld;
         ex_mem_wr_o <= !bubble && is_st;
         ex_halt_o   <= !bubble && is_halt;
         halt_seen   <= halt_seen || is_halt;
         err_o       <= undef;
      end
   end

   // Operand payload of ID/EX
   always_ff @(posedge clk) begin
      ex_rs_o     <= if_inst_i.r.rs;
      ex_rt_o     <= if_inst_i.r.rt;
      ex_dst_o    <= dst;
      ex_rs_val_o <= rs_val;
      ex_rt_val_o <= rt_val;
      ex_imm_o    <= if_inst_i.i.imm;
   end

   // HALT reads no registers, so it can never be stalled behind a load
   a_no_stall_during_halt : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(stall_o && halt_hold_o)
   );

endmodule

`default_nettype wire

// ==== src/inst_fetch.sv ====
`default_nettype none

module inst_fetch #(
   parameter int DATA_W = 32
) (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       stall_i,
   input  wire                       halt_hold_i,
   input  wire proc_pkg::inst_word_u inst_i,
   output logic [DATA_W-1:0]         iaddr_o,
   output proc_pkg::inst_word_u      if_inst_o
);

   import proc_pkg::*;

   logic hold;
   logic at_halt;

   // Stall and halt both freeze the front end
   assign hold = stall_i | halt_hold_i;

   // A fetched HALT parks the PC on its own address
   assign at_halt = (inst_i.r.opc == OPC_HALT);

   // PC and IF/ID register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         iaddr_o   <= '0;
         if_inst_o <= NOP_INST;
      end else if (!hold) begin
         if_inst_o <= inst_i;
         if (!at_halt) begin
            iaddr_o <= iaddr_o + DATA_W'(1);
         end
      end
   end

   // Once decode holds for HALT the fetch address is frozen
   a_pc_frozen_on_halt : assert property (
      @(posedge clk) disable iff (!rst_n)
      halt_hold_i |=> $stable(iaddr_o)
   );

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file #(
   parameter int DATA_W = 32
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire [proc_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
   output logic [DATA_W-1:0]              rd_data_a_o,
   output logic [DATA_W-1:0]              rd_data_b_o,
   input  wire                            wr_en_i,
   input  wire [proc_pkg::REG_ADDR_W-1:0] wr_addr_i,
   input  wire [DATA_W-1:0]               wr_data_i
);

   import proc_pkg::*;

   logic [DATA_W-1:0] regs [2**REG_ADDR_W];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // Write-through, a same-cycle write wins over the stored value
   function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
      if (wr_en_i && (wr_addr_i == addr)) begin
         return wr_data_i;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rd_data_a_o = read_port(rd_addr_a_i);
      rd_data_b_o = read_port(rd_addr_b_i);
   end

endmodule

`default_nettype wire

// ==== src/proc_pkg.sv ====
`default_nettype none

package proc_pkg;

   localparam int INST_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int OPC_W      = 6;
   localparam int IMM_W      = 16;

   ////////////////////////////////////////////////////////////////////////////
   // Opcodes in bits 31:26, every value not listed here is undefined
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [OPC_W-1:0] OPC_NOP  = 6'h00;
   localparam logic [OPC_W-1:0] OPC_ADD  = 6'h01;
   localparam logic [OPC_W-1:0] OPC_SUB  = 6'h02;
   localparam logic [OPC_W-1:0] OPC_AND  = 6'h03;
   localparam logic [OPC_W-1:0] OPC_OR   = 6'h04;
   localparam logic [OPC_W-1:0] OPC_XOR  = 6'h05;
   localparam logic [OPC_W-1:0] OPC_SLT  = 6'h06;
   localparam logic [OPC_W-1:0] OPC_ADDI = 6'h08;
   localparam logic [OPC_W-1:0] OPC_ORI  = 6'h09;
   localparam logic [OPC_W-1:0] OPC_XORI = 6'h0a;
   localparam logic [OPC_W-1:0] OPC_LD   = 6'h10;
   localparam logic [OPC_W-1:0] OPC_ST   = 6'h11;
   localparam logic [OPC_W-1:0] OPC_HALT = 6'h3f;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction word
   ////////////////////////////////////////////////////////////////////////////

   // Register to register, result goes to rd
   typedef struct packed {
      logic [OPC_W-1:0]      opc;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [10:0]           unused;
   } r_fmt_t;

   // Immediate form, rt is the destination except for ST where it is the data
   typedef struct packed {
      logic [OPC_W-1:0]      opc;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [IMM_W-1:0]      imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } inst_word_u;

   // Reset value of IF/ID and the word used for bubbles
   localparam inst_word_u NOP_INST = inst_word_u'({OPC_NOP, {(INST_W-OPC_W){1'b0}}});

endpackage

`default_nettype wire
